// File: Makefile
# Verilator build and run for the predecoder testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module predecoderTb -o simv
	-./obj_dir/simv > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "test did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: source/boundaryScan.sv
//############################################################
// instruction boundary scan: starts, magic bits and error
//############################################################
`timescale 1ns/100ps
`default_nettype none

module boundaryScan import predecodePkg::*; (
  input wire bundleT bundle,
  input wire offsetT startOff,
  output parcelMaskT starts,
  output magicT [parcelCount-1:0] magic,
  output logic error
);

  parcelMaskT endBits;
  parcelMaskT prevEnd; // end bit of parcel k-1
  parcelMaskT firstBit;
  parcelMaskT offMask;
  logic [parcelCount+magicWidth-2:0] endExt; // zero end bits past the bundle
  logic [countWidth-1:0] startCnt;

  always_comb begin
    for (int k = 0; k < parcelCount; k++) begin
      endBits[k] = bundle[k*parcelWidth+endBit];
    end
  end

  assign prevEnd = {endBits[parcelCount-2:0], 1'b0};
  assign firstBit = parcelMaskT'(1) << startOff;
  assign offMask = ~(firstBit - parcelMaskT'(1)); // at or above startOff

  // first start is taken regardless of the previous end bit
  assign starts = firstBit | (offMask & prevEnd);

  assign endExt = {{(magicWidth-1){1'b0}}, endBits};

  always_comb begin
    for (int k = 0; k < parcelCount; k++) begin
      magic[k] = ~endExt[k +: magicWidth];
    end
  end

  always_comb begin
    startCnt = '0;
    for (int k = 0; k < parcelCount; k++) begin
      if (starts[k]) startCnt = startCnt + countWidth'(1);
    end
  end

  // too many starts, or an instruction starting in the last parcel
  assign error = int'(startCnt) > slotCount || startOff == offsetT'(parcelCount - 1);

endmodule

`default_nettype wire

// File: source/instrClassify.sv
//############################################################
// instruction classifier for one parcel position
//############################################################
`timescale 1ns/100ps
`default_nettype none

module instrClassify import predecodePkg::*; (
  input wire headT head,
  input wire magicT magic,
  output classT cls
);

  logic [7:0] op; // long-form opcode
  logic [5:0] sub; // short-form sub-opcode
  logic [1:0] jSub; // sub-field of opcode 182
  logic longForm;
  logic isJumpReg;
  logic isIndir;
  logic isCall;
  logic isRet;

  assign op = head[7:0];
  assign sub = head[5:0];
  assign jSub = head[14:13];
  assign longForm = magic[0];

  // opcode 182 is the register jump family
  assign isJumpReg = op == 8'd182;
  assign isIndir = isJumpReg && jSub == 2'd0;
  assign isCall = isJumpReg && (jSub == 2'd1 || jSub == 2'd2);
  assign isRet = isJumpReg && jSub == 2'd3;

  always_comb begin
    cls = '0;
    if (longForm) begin
      cls[classAlu] = (op < 8'd40 && !op[2])
        || (op >= 8'd46 && op <= 8'd53) // compare and test
        || (op >= 8'd194 && op <= 8'd198)
        || op == 8'd210
        || op == 8'd211;
      cls[classMul] = (op < 8'd40 && op[2]) || op == 8'd212;
      cls[classShift] = op >= 8'd40 && op <= 8'd45;
      cls[classLoad] = op[7:6] == 2'b01 && !op[0]; // 64..127
      cls[classStore] = (op[7:6] == 2'b01 && op[0]) || isCall;
      cls[classJump] = op[7:4] == 4'ha // 160..175
        || (op >= 8'd178 && op <= 8'd181)
        || isJumpReg;
      cls[classIndir] = isIndir || isRet;
      cls[classFpu] = op == 8'hf0;
      cls[classSys] = op == 8'hff;
    end else begin
      // short form
      cls[classAlu] = sub < 6'd20 || (sub >= 6'd32 && sub <= 6'd41);
      cls[classJump] = sub[5:2] == 4'b1100; // 48..51
      cls[classFpu] = sub >= 6'd52;
    end
  end

endmodule

`default_nettype wire

// File: source/predecodePkg.sv
//############################################################
// predecoder shared widths, counts, class bits and types
//############################################################
`default_nettype none

package predecodePkg;

  // bundle geometry
  localparam int parcelWidth = 16;
  localparam int parcelCount = 16;
  localparam int bundleWidth = parcelWidth * parcelCount;
  localparam int instrWidth = 80; // five parcels per slot
  localparam int headWidth = 32; // two parcels seen by the classifier
  localparam int magicWidth = 4;
  localparam int endBit = 15; // end marker inside a parcel

  // slot counts
  localparam int slotCount = 8;
  localparam int jumpSlotCount = 4;
  localparam int countWidth = 5; // holds 0..parcelCount

  // class vector bits
  localparam int classJump = 0;
  localparam int classIndir = 1;
  localparam int classAlu = 2;
  localparam int classShift = 3;
  localparam int classMul = 4;
  localparam int classLoad = 5;
  localparam int classStore = 6;
  localparam int classFpu = 7;
  localparam int classSys = 8;
  localparam int classWidth = 9;

  typedef logic [bundleWidth-1:0] bundleT;
  typedef logic [instrWidth-1:0] instrT;
  typedef logic [headWidth-1:0] headT;
  typedef logic [magicWidth-1:0] magicT; // bit 0 set means long form
  typedef logic [3:0] offsetT;
  typedef logic [classWidth-1:0] classT;
  typedef logic [parcelCount-1:0] parcelMaskT;

endpackage

`default_nettype wire

// File: source/predecoder.sv
//############################################################
// fetch bundle predecoder with one registered output stage
//############################################################
`timescale 1ns/100ps
`default_nettype none

module predecoder import predecodePkg::*; (
  input wire clk,
  input wire rstN,
  input wire bundleT bundle,
  input wire offsetT startOff,
  output instrT [slotCount-1:0] instr,
  output magicT [slotCount-1:0] magic,
  output offsetT [slotCount-1:0] off,
  output classT [slotCount-1:0] cls,
  output logic [slotCount-1:0] instrEn,
  output instrT [jumpSlotCount-1:0] jumpInstr,
  output magicT [jumpSlotCount-1:0] jumpMagic,
  output offsetT [jumpSlotCount-1:0] jumpOff,
  output classT [jumpSlotCount-1:0] jumpCls,
  output logic [jumpSlotCount-1:0] jumpEn,
  output logic hasJumps,
  output logic error,
  output logic jumpOverflow
);

  parcelMaskT starts;
  parcelMaskT jumpMask;
  magicT [parcelCount-1:0] parcelMagic;
  classT [parcelCount-1:0] parcelCls;
  logic [bundleWidth+headWidth-parcelWidth-1:0] headExt;
  logic [countWidth-1:0] jumpCnt;
  logic errorNext;

  instrT [slotCount-1:0] instrNext;
  magicT [slotCount-1:0] magicNext;
  offsetT [slotCount-1:0] offNext;
  classT [slotCount-1:0] clsNext;
  logic [slotCount-1:0] instrEnNext;
  instrT [jumpSlotCount-1:0] jumpInstrNext;
  magicT [jumpSlotCount-1:0] jumpMagicNext;
  offsetT [jumpSlotCount-1:0] jumpOffNext;
  classT [jumpSlotCount-1:0] jumpClsNext;
  logic [jumpSlotCount-1:0] jumpEnNext;

  boundaryScan scan (
    .bundle(bundle), .startOff(startOff),
    .starts(starts), .magic(parcelMagic), .error(errorNext)
  );

  assign headExt = {{(headWidth-parcelWidth){1'b0}}, bundle};

  // one classifier per parcel, jump mask keeps only real starts
  for (genvar k = 0; k < parcelCount; k++) begin : genClassify
    instrClassify classify (
      .head(headExt[k*parcelWidth +: headWidth]),
      .magic(parcelMagic[k]),
      .cls(parcelCls[k])
    );
    assign jumpMask[k] = starts[k] & parcelCls[k][classJump];
  end

  slotCompact #(.slots(slotCount)) instrSlots (
    .sel(starts), .bundle(bundle), .magicIn(parcelMagic), .clsIn(parcelCls),
    .instr(instrNext), .magic(magicNext), .off(offNext), .cls(clsNext),
    .en(instrEnNext)
  );

  slotCompact #(.slots(jumpSlotCount)) jumpSlots (
    .sel(jumpMask), .bundle(bundle), .magicIn(parcelMagic), .clsIn(parcelCls),
    .instr(jumpInstrNext), .magic(jumpMagicNext), .off(jumpOffNext),
    .cls(jumpClsNext), .en(jumpEnNext)
  );

  always_comb begin
    jumpCnt = '0;
    for (int k = 0; k < parcelCount; k++) begin
      if (jumpMask[k]) jumpCnt = jumpCnt + countWidth'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      instr <= '0;
      magic <= '0;
      off <= '0;
      cls <= '0;
      instrEn <= '0;
      jumpInstr <= '0;
      jumpMagic <= '0;
      jumpOff <= '0;
      jumpCls <= '0;
      jumpEn <= '0;
      hasJumps <= 1'b0;
      error <= 1'b0;
      jumpOverflow <= 1'b0;
    end else begin
      instr <= instrNext;
      magic <= magicNext;
      off <= offNext;
      cls <= clsNext;
      instrEn <= instrEnNext;
      jumpInstr <= jumpInstrNext;
      jumpMagic <= jumpMagicNext;
      jumpOff <= jumpOffNext;
      jumpCls <= jumpClsNext;
      jumpEn <= jumpEnNext;
      hasJumps <= |jumpMask;
      error <= errorNext;
      jumpOverflow <= int'(jumpCnt) > jumpSlotCount; // jumps beyond the slots
    end
  end

endmodule

`default_nettype wire

// File: source/slotCompact.sv
//############################################################
// slot compactor: routes the first marked parcels to slots
//############################################################
`timescale 1ns/100ps
`default_nettype none

module slotCompact import predecodePkg::*; #(
  parameter int slots = 8
) (
  input wire parcelMaskT sel,
  input wire bundleT bundle,
  input wire magicT [parcelCount-1:0] magicIn,
  input wire classT [parcelCount-1:0] clsIn,
  output instrT [slots-1:0] instr,
  output magicT [slots-1:0] magic,
  output offsetT [slots-1:0] off,
  output classT [slots-1:0] cls,
  output logic [slots-1:0] en
);

  logic [bundleWidth+instrWidth-parcelWidth-1:0] padded;
  logic [parcelCount-1:0][countWidth-1:0] rank; // marked parcels below k
  logic [countWidth-1:0] total;

  // text past the bundle reads as zero
  assign padded = {{(instrWidth-parcelWidth){1'b0}}, bundle};

  always_comb begin
    total = '0;
    for (int k = 0; k < parcelCount; k++) begin
      rank[k] = total;
      if (sel[k]) total = total + countWidth'(1);
    end
  end

  always_comb begin
    instr = '0;
    magic = '0;
    off = '0;
    cls = '0;
    for (int i = 0; i < slots; i++) begin
      for (int k = 0; k < parcelCount; k++) begin
        if (sel[k] && int'(rank[k]) == i) begin
          instr[i] = padded[k*parcelWidth +: instrWidth];
          magic[i] = magicIn[k];
          off[i] = offsetT'(k);
          cls[i] = clsIn[k];
        end
      end
      en[i] = int'(total) > i; // thermometer
    end
  end

endmodule

`default_nettype wire

// File: test/predecoderTb.sv
//############################################################
// predecoder testbench, LFSR bundles checked against a model
//############################################################
`timescale 1ns/100ps
`default_nettype none

module predecoderTb import predecodePkg::*; ();

  localparam int resetCycles = 4;
  localparam int directedCycles = 11;
  localparam int randomCycles = 2000;
  localparam int cycleLimit = resetCycles + directedCycles + randomCycles + 50;

  logic clk = 1'b0;
  logic rstN;
  bundleT bundle;
  offsetT startOff;
  instrT [slotCount-1:0] instr;
  magicT [slotCount-1:0] magic;
  offsetT [slotCount-1:0] off;
  classT [slotCount-1:0] cls;
  logic [slotCount-1:0] instrEn;
  instrT [jumpSlotCount-1:0] jumpInstr;
  magicT [jumpSlotCount-1:0] jumpMagic;
  offsetT [jumpSlotCount-1:0] jumpOff;
  classT [jumpSlotCount-1:0] jumpCls;
  logic [jumpSlotCount-1:0] jumpEn;
  logic hasJumps;
  logic error;
  logic jumpOverflow;

  logic [15:0] lfsr;
  int cycleCount = 0;

  // model results, one entry per filled slot
  instrT expInstr[$];
  magicT expMagic[$];
  offsetT expOff[$];
  classT expCls[$];
  instrT expJInstr[$];
  magicT expJMagic[$];
  offsetT expJOff[$];
  classT expJCls[$];
  logic expHasJumps;
  logic expError;
  logic expOverflow;

  predecoder UUT (
    .clk(clk), .rstN(rstN), .bundle(bundle), .startOff(startOff),
    .instr(instr), .magic(magic), .off(off), .cls(cls), .instrEn(instrEn),
    .jumpInstr(jumpInstr), .jumpMagic(jumpMagic), .jumpOff(jumpOff),
    .jumpCls(jumpCls), .jumpEn(jumpEn), .hasJumps(hasJumps),
    .error(error), .jumpOverflow(jumpOverflow)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      failNow($sformatf("Timeout: run still going after %0d cycles", cycleLimit));
    end
  end

  task automatic failNow(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      val = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  function automatic logic [parcelWidth-1:0] parcelAt(input bundleT b, input int k);
    if (k < parcelCount) return b[k*parcelWidth +: parcelWidth];
    return '0; // past the bundle
  endfunction

  function automatic classT classOf(input logic [parcelWidth-1:0] p, input logic longForm);
    classT c;
    int op;
    int sub;
    int js;
    c = '0;
    op = int'(p[7:0]);
    sub = int'(p[5:0]);
    js = int'(p[14:13]);
    if (longForm) begin
      if (op < 40) begin
        if (op % 8 < 4) c[classAlu] = 1'b1; // bit 2 splits alu and mul
        else c[classMul] = 1'b1;
      end
      if ((op >= 46 && op <= 53) || (op >= 194 && op <= 198) || op == 210 || op == 211)
        c[classAlu] = 1'b1;
      if (op == 212) c[classMul] = 1'b1;
      if (op >= 40 && op <= 45) c[classShift] = 1'b1;
      if (op >= 64 && op <= 127) begin
        if (op % 2 == 0) c[classLoad] = 1'b1;
        else c[classStore] = 1'b1;
      end
      if ((op >= 160 && op <= 175) || (op >= 178 && op <= 182)) c[classJump] = 1'b1;
      if (op == 182) begin
        if (js == 0 || js == 3) c[classIndir] = 1'b1;
        else c[classStore] = 1'b1; // calls push a return address
      end
      if (op == 240) c[classFpu] = 1'b1;
      if (op == 255) c[classSys] = 1'b1;
    end else begin
      if (sub < 20 || (sub >= 32 && sub <= 41)) c[classAlu] = 1'b1;
      if (sub >= 48 && sub <= 51) c[classJump] = 1'b1;
      if (sub >= 52) c[classFpu] = 1'b1;
    end
    return c;
  endfunction

  task automatic clearModel();
    expInstr.delete();
    expMagic.delete();
    expOff.delete();
    expCls.delete();
    expJInstr.delete();
    expJMagic.delete();
    expJOff.delete();
    expJCls.delete();
    expHasJumps = 1'b0;
    expError = 1'b0;
    expOverflow = 1'b0;
  endtask

  task automatic computeModel(input bundleT b, input offsetT o);
    parcelMaskT e;
    parcelMaskT st;
    magicT mg [parcelCount];
    classT cl [parcelCount];
    instrT text;
    int n;
    int nj;
    clearModel();
    n = 0;
    nj = 0;
    for (int k = 0; k < parcelCount; k++) begin
      e[k] = b[k*parcelWidth + endBit];
    end
    for (int k = 0; k < parcelCount; k++) begin
      if (k == int'(o)) st[k] = 1'b1;
      else if (k > int'(o)) st[k] = e[k-1];
      else st[k] = 1'b0;
      for (int j = 0; j < magicWidth; j++) begin
        mg[k][j] = (k + j < parcelCount) ? ~e[k+j] : 1'b1;
      end
      cl[k] = classOf(parcelAt(b, k), mg[k][0]);
    end
    for (int k = 0; k < parcelCount; k++) begin
      if (st[k]) begin
        for (int p = 0; p < instrWidth / parcelWidth; p++) begin
          text[p*parcelWidth +: parcelWidth] = parcelAt(b, k + p);
        end
        if (n < slotCount) begin
          expInstr.push_back(text);
          expMagic.push_back(mg[k]);
          expOff.push_back(offsetT'(k));
          expCls.push_back(cl[k]);
        end
        n++;
        if (cl[k][classJump]) begin
          if (nj < jumpSlotCount) begin
            expJInstr.push_back(text);
            expJMagic.push_back(mg[k]);
            expJOff.push_back(offsetT'(k));
            expJCls.push_back(cl[k]);
          end
          nj++;
        end
      end
    end
    expHasJumps = nj > 0;
    expError = n > slotCount || o == offsetT'(parcelCount - 1);
    expOverflow = nj > jumpSlotCount;
  endtask

  task automatic checkInstr(input string name, input instrT got, input instrT exp);
    if (got !== exp) failNow($sformatf("Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic checkMagic(input string name, input magicT got, input magicT exp);
    if (got !== exp) failNow($sformatf("Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic checkOff(input string name, input offsetT got, input offsetT exp);
    if (got !== exp) failNow($sformatf("Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic checkClass(input string name, input classT got, input classT exp);
    if (got !== exp) failNow($sformatf("Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic checkEnable(input string name, input logic [slotCount-1:0] got,
                             input logic [slotCount-1:0] exp);
    if (got !== exp) failNow($sformatf("Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) failNow($sformatf("Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic checkOutputs();
    logic [slotCount-1:0] en;
    logic [jumpSlotCount-1:0] jEn;
    for (int i = 0; i < slotCount; i++) begin
      en[i] = i < expInstr.size();
      checkInstr($sformatf("instr[%0d]", i), instr[i], en[i] ? expInstr[i] : '0);
      checkMagic($sformatf("magic[%0d]", i), magic[i], en[i] ? expMagic[i] : '0);
      checkOff($sformatf("off[%0d]", i), off[i], en[i] ? expOff[i] : '0);
      checkClass($sformatf("cls[%0d]", i), cls[i], en[i] ? expCls[i] : '0);
    end
    for (int i = 0; i < jumpSlotCount; i++) begin
      jEn[i] = i < expJInstr.size();
      checkInstr($sformatf("jumpInstr[%0d]", i), jumpInstr[i], jEn[i] ? expJInstr[i] : '0);
      checkMagic($sformatf("jumpMagic[%0d]", i), jumpMagic[i], jEn[i] ? expJMagic[i] : '0);
      checkOff($sformatf("jumpOff[%0d]", i), jumpOff[i], jEn[i] ? expJOff[i] : '0);
      checkClass($sformatf("jumpCls[%0d]", i), jumpCls[i], jEn[i] ? expJCls[i] : '0);
    end
    checkEnable("instrEn", instrEn, en);
    checkEnable("jumpEn", slotCount'(jumpEn), slotCount'(jEn));
    checkFlag("hasJumps", hasJumps, expHasJumps);
    checkFlag("error", error, expError);
    checkFlag("jumpOverflow", jumpOverflow, expOverflow);
  endtask

  // check the last bundle, then drive the next one
  task automatic applyBundle(input bundleT b, input offsetT o);
    @(negedge clk);
    checkOutputs();
    rstN = 1'b1; // reset ends with the first bundle
    bundle = b;
    startOff = o;
    computeModel(b, o);
  endtask

  function automatic bundleT uniformBundle(input logic [parcelWidth-1:0] p);
    return {parcelCount{p}};
  endfunction

  task automatic directedTests();
    bundleT b;
    logic [7:0] ops [slotCount];
    b = uniformBundle(16'h8005); // one-parcel alu ops
    applyBundle(b, 4'd0);
    applyBundle(b, 4'd7); // nine starts
    applyBundle(b, 4'd8); // exactly eight
    applyBundle(b, 4'd15);
    b = uniformBundle(16'h0040); // no end bits at all
    applyBundle(b, 4'd3);
    applyBundle(b, 4'd0);
    b = uniformBundle(16'h8031); // short-form jumps
    applyBundle(b, 4'd12);
    applyBundle(b, 4'd11);
    // two-parcel register jumps cycling through the sub-field
    for (int i = 0; i < slotCount; i++) begin
      b[2*i*parcelWidth +: parcelWidth] = {1'b0, 2'(i % 4), 5'd0, 8'd182};
      b[(2*i+1)*parcelWidth +: parcelWidth] = 16'h8000 | 16'(i);
    end
    applyBundle(b, 4'd0);
    applyBundle(b, 4'd1);
    ops = '{8'h04, 8'h28, 8'h30, 8'h41, 8'ha5, 8'hf0, 8'hff, 8'hd4};
    for (int i = 0; i < slotCount; i++) begin
      b[2*i*parcelWidth +: parcelWidth] = {8'h00, ops[i]};
      b[(2*i+1)*parcelWidth +: parcelWidth] = 16'h8000 | 16'(i);
    end
    applyBundle(b, 4'd0);
  endtask

  task automatic randomCycle();
    bundleT b;
    offsetT o;
    logic [1:0] density;
    logic [1:0] roll;
    logic [14:0] body;
    density = 2'(takeBits(2)); // 0 gives no end bits, 3 gives dense bundles
    o = offsetT'(takeBits(4));
    for (int k = 0; k < parcelCount; k++) begin
      body = 15'(takeBits(15));
      roll = 2'(takeBits(2));
      b[k*parcelWidth +: parcelWidth] = {roll < density, body};
    end
    applyBundle(b, o);
  endtask

  initial begin
    rstN = 1'b0;
    bundle = '0;
    startOff = '0;
    lfsr = 16'd15;
    clearModel();
    repeat (resetCycles - 1) begin
      @(negedge clk);
      checkOutputs();
    end
    directedTests();
    repeat (randomCycles) randomCycle();
    @(negedge clk);
    checkOutputs();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/predecoder_assert.sv
//############################################################
// predecoder output checks, bound into the top level
//############################################################
`timescale 1ns/100ps
`default_nettype none

module predecoderAssert import predecodePkg::*; (
  input wire clk,
  input wire rstN,
  input wire [slotCount-1:0] instrEn,
  input wire [jumpSlotCount-1:0] jumpEn,
  input wire instrT [slotCount-1:0] instr,
  input wire offsetT [slotCount-1:0] off,
  input wire instrT [jumpSlotCount-1:0] jumpInstr,
  input wire hasJumps
);

  // enables fill from slot 0 upward
  instrEnThermo: assert property (@(posedge clk) disable iff (!rstN)
    (instrEn & (instrEn + slotCount'(1))) == '0)
    else $error("instrEn is not a thermometer code");

  jumpEnThermo: assert property (@(posedge clk) disable iff (!rstN)
    (jumpEn & (jumpEn + jumpSlotCount'(1))) == '0)
    else $error("jumpEn is not a thermometer code");

  jumpFlag: assert property (@(posedge clk) disable iff (!rstN) hasJumps == jumpEn[0])
    else $error("hasJumps disagrees with the first jump slot enable");

  for (genvar i = 0; i < slotCount; i++) begin : genSlot
    slotClear: assert property (@(posedge clk) disable iff (!rstN)
      !instrEn[i] |-> instr[i] == '0 && off[i] == '0)
      else $error("instruction slot %0d holds data while disabled", i);
  end

  for (genvar i = 0; i < jumpSlotCount; i++) begin : genJumpSlot
    jumpClear: assert property (@(posedge clk) disable iff (!rstN)
      !jumpEn[i] |-> jumpInstr[i] == '0)
      else $error("jump slot %0d holds data while disabled", i);
  end

endmodule

bind predecoder predecoderAssert checks (
  .clk(clk), .rstN(rstN), .instrEn(instrEn), .jumpEn(jumpEn),
  .instr(instr), .off(off), .jumpInstr(jumpInstr), .hasJumps(hasJumps)
);

`default_nettype wire

// File: verilog.f
source/predecodePkg.sv
source/instrClassify.sv
source/boundaryScan.sv
source/slotCompact.sv
source/predecoder.sv
test/predecoder_assert.sv
test/predecoderTb.sv
